/* rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    // Datapath and register index widths
    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    // Load and store widths from funct3
    localparam logic [2:0] F3_B  = 3'd0;
    localparam logic [2:0] F3_H  = 3'd1;
    localparam logic [2:0] F3_W  = 3'd2;
    localparam logic [2:0] F3_BU = 3'd4;
    localparam logic [2:0] F3_HU = 3'd5;

    // Writeback result source
    localparam logic [1:0] RES_ALU = 2'd0;
    localparam logic [1:0] RES_MEM = 2'd1;
    localparam logic [1:0] RES_PC4 = 2'd2;

endpackage

`default_nettype wire

/* rv_mem_pkg.sv */
`default_nettype none

package rv_mem_pkg;

    // Data RAM depth in 32-bit words
    localparam int DMEM_WORDS = 256;

    // Byte address bits above DMEM_AW+1 are dropped
    localparam int DMEM_AW = $clog2(DMEM_WORDS);

    // One enable per byte lane
    localparam int BE_W = 4;

endpackage

`default_nettype wire

/* core_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module core_memory
    import rv_isa_pkg::*;
(
    input  wire  [2:0]          i_funct3,
    input  wire  [1:0]          i_alu_result_low,
    input  wire  [XLEN-1:0]     i_rs2_val,
    output logic [XLEN-1:0]     o_wdata,
    output logic [XLEN/8-1:0]   o_mem_sel
);

    // Replicate store data into every lane it may land in
    always_comb
    begin
        case (i_funct3)
            F3_B, F3_BU:
            begin
                o_wdata   = {4{i_rs2_val[7:0]}};
                o_mem_sel = 4'b0001 << i_alu_result_low;
            end
            F3_H, F3_HU:
            begin
                o_wdata   = {2{i_rs2_val[15:0]}};
                o_mem_sel = i_alu_result_low[1] ? 4'b1100 : 4'b0011;
            end
            default:
            begin
                o_wdata   = i_rs2_val;
                o_mem_sel = 4'b1111;
            end
        endcase
    end

endmodule

`default_nettype wire

/* rv_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_memory
    import rv_isa_pkg::*;
(
    input  wire                 i_clk,
    input  wire                 i_rst_n,

    input  wire  [XLEN-1:0]     i_alu_result,
    input  wire                 i_reg_write,
    input  wire                 i_mem_read,
    input  wire                 i_mem_write,
    input  wire  [REG_AW-1:0]   i_rd,
    input  wire  [1:0]          i_res_src,
    input  wire  [2:0]          i_funct3,
    input  wire  [XLEN-1:2]     i_pc_p4,
    input  wire  [XLEN-1:0]     i_rs2_val,
    input  wire  [XLEN-1:2]     i_pc_target,

    output logic [XLEN-1:0]     o_alu_result,
    output logic                o_reg_write,
    output logic [1:0]          o_res_src,
    output logic [REG_AW-1:0]   o_rd,
    output logic [XLEN-1:2]     o_pc_p4,
    output logic [2:0]          o_funct3,
    output logic [XLEN-1:2]     o_pc_target,
    output logic                o_mem_write,
    output logic                o_mem_read,
    output logic [XLEN/8-1:0]   o_mem_sel,
    output logic [XLEN-1:0]     o_wdata
);

    logic [XLEN-1:0] r_rs2_val;

    // Control strobes
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            o_reg_write <= 1'b0;
            o_mem_read  <= 1'b0;
            o_mem_write <= 1'b0;
        end
        else
        begin
            o_reg_write <= i_reg_write;
            o_mem_read  <= i_mem_read;
            o_mem_write <= i_mem_write;
        end
    end

    // Datapath
    always_ff @(posedge i_clk)
    begin
        o_alu_result <= i_alu_result;
        o_res_src    <= i_res_src;
        o_rd         <= i_rd;
        o_pc_p4      <= i_pc_p4;
        o_funct3     <= i_funct3;
        o_pc_target  <= i_pc_target;
        r_rs2_val    <= i_rs2_val;
    end

    // Lane formatting after the register
    core_memory u_core_memory
    (
        .i_funct3         (o_funct3),
        .i_alu_result_low (o_alu_result[1:0]),
        .i_rs2_val        (r_rs2_val),
        .o_wdata          (o_wdata),
        .o_mem_sel        (o_mem_sel)
    );

endmodule

`default_nettype wire

/* rv_dmem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_dmem_arbiter
    import rv_isa_pkg::*;
    import rv_mem_pkg::*;
(
    input  wire                 i_clk,
    input  wire                 i_rst_n,

    input  wire                 i_core_req,
    input  wire                 i_core_we,
    input  wire  [BE_W-1:0]     i_core_be,
    input  wire  [DMEM_AW-1:0]  i_core_addr,
    input  wire  [XLEN-1:0]     i_core_wdata,

    input  wire                 i_dbg_req,
    input  wire                 i_dbg_we,
    input  wire  [BE_W-1:0]     i_dbg_be,
    input  wire  [DMEM_AW-1:0]  i_dbg_addr,
    input  wire  [XLEN-1:0]     i_dbg_wdata,
    output logic                o_dbg_gnt,
    output logic                o_dbg_rvalid,
    output logic [XLEN-1:0]     o_dbg_rdata,

    output logic                o_mem_en,
    output logic                o_mem_we,
    output logic [BE_W-1:0]     o_mem_be,
    output logic [DMEM_AW-1:0]  o_mem_addr,
    output logic [XLEN-1:0]     o_mem_wdata,
    input  wire  [XLEN-1:0]     i_mem_rdata
);

    // Core always wins and debug only gets idle cycles
    assign o_dbg_gnt = i_dbg_req & ~i_core_req;
    assign o_mem_en  = i_core_req | o_dbg_gnt;

    always_comb
    begin
        if (i_core_req)
        begin
            o_mem_we    = i_core_we;
            o_mem_be    = i_core_be;
            o_mem_addr  = i_core_addr;
            o_mem_wdata = i_core_wdata;
        end
        else
        begin
            o_mem_we    = o_dbg_gnt & i_dbg_we;
            o_mem_be    = i_dbg_be;
            o_mem_addr  = i_dbg_addr;
            o_mem_wdata = i_dbg_wdata;
        end
    end

    // Read data arrives one cycle after a granted debug read
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
            o_dbg_rvalid <= 1'b0;
        else
            o_dbg_rvalid <= o_dbg_gnt & ~i_dbg_we;
    end

    assign o_dbg_rdata = i_mem_rdata;

endmodule

`default_nettype wire

/* rv_dmem.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_dmem
    import rv_isa_pkg::*;
    import rv_mem_pkg::*;
(
    input  wire                 i_clk,
    input  wire                 i_en,
    input  wire                 i_we,
    input  wire  [BE_W-1:0]     i_be,
    input  wire  [DMEM_AW-1:0]  i_addr,
    input  wire  [XLEN-1:0]     i_wdata,
    output logic [XLEN-1:0]     o_rdata
);

    logic [XLEN-1:0] mem [DMEM_WORDS];

    always_ff @(posedge i_clk)
    begin
        if (i_en)
        begin
            if (i_we)
            begin
                for (int i = 0; i < BE_W; i++)
                begin
                    if (i_be[i])
                        mem[i_addr][8*i +: 8] <= i_wdata[8*i +: 8];
                end
            end
            // Old word on a write
            o_rdata <= mem[i_addr];
        end
    end

endmodule

`default_nettype wire

/* rv_writeback.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_writeback
    import rv_isa_pkg::*;
(
    input  wire                 i_clk,
    input  wire                 i_rst_n,

    input  wire                 i_reg_write,
    input  wire  [1:0]          i_res_src,
    input  wire  [REG_AW-1:0]   i_rd,
    input  wire  [2:0]          i_funct3,
    input  wire  [XLEN-1:0]     i_alu_result,
    input  wire  [XLEN-1:2]     i_pc_p4,
    input  wire  [XLEN-1:0]     i_mem_rdata,

    output logic [XLEN-1:0]     o_wb_data,
    output logic [REG_AW-1:0]   o_wb_rd,
    output logic                o_wb_reg_write
);

    logic [1:0]      r_res_src;
    logic [2:0]      r_funct3;
    logic [XLEN-1:0] r_alu_result;
    logic [XLEN-1:2] r_pc_p4;
    logic [XLEN-1:0] load_shift;
    logic [XLEN-1:0] load_data;

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
            o_wb_reg_write <= 1'b0;
        else
            o_wb_reg_write <= i_reg_write;
    end

    always_ff @(posedge i_clk)
    begin
        r_res_src    <= i_res_src;
        o_wb_rd      <= i_rd;
        r_funct3     <= i_funct3;
        r_alu_result <= i_alu_result;
        r_pc_p4      <= i_pc_p4;
    end

    // Bring the addressed lane down to bit 0
    assign load_shift = i_mem_rdata >> {r_alu_result[1:0], 3'b000};

    always_comb
    begin
        case (r_funct3)
            F3_B:    load_data = {{(XLEN-8){load_shift[7]}}, load_shift[7:0]};
            F3_H:    load_data = {{(XLEN-16){load_shift[15]}}, load_shift[15:0]};
            F3_BU:   load_data = {{(XLEN-8){1'b0}}, load_shift[7:0]};
            F3_HU:   load_data = {{(XLEN-16){1'b0}}, load_shift[15:0]};
            default: load_data = load_shift;
        endcase
    end

    always_comb
    begin
        case (r_res_src)
            RES_MEM: o_wb_data = load_data;
            RES_PC4: o_wb_data = {r_pc_p4, 2'b00};
            default: o_wb_data = r_alu_result;
        endcase
    end

endmodule

`default_nettype wire

/* rv_mem_stage_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_mem_stage_top
    import rv_isa_pkg::*;
    import rv_mem_pkg::*;
(
    input  wire                 i_clk,
    input  wire                 i_rst_n,

    input  wire  [XLEN-1:0]     i_alu_result,
    input  wire                 i_reg_write,
    input  wire                 i_mem_read,
    input  wire                 i_mem_write,
    input  wire  [REG_AW-1:0]   i_rd,
    input  wire  [1:0]          i_res_src,
    input  wire  [2:0]          i_funct3,
    input  wire  [XLEN-1:2]     i_pc_p4,
    input  wire  [XLEN-1:0]     i_rs2_val,
    input  wire  [XLEN-1:2]     i_pc_target,

    input  wire                 i_dbg_req,
    input  wire                 i_dbg_we,
    input  wire  [BE_W-1:0]     i_dbg_be,
    input  wire  [DMEM_AW-1:0]  i_dbg_addr,
    input  wire  [XLEN-1:0]     i_dbg_wdata,
    output logic                o_dbg_gnt,
    output logic                o_dbg_rvalid,
    output logic [XLEN-1:0]     o_dbg_rdata,

    output logic [XLEN-1:2]     o_pc_target,
    output logic [XLEN-1:0]     o_wb_data,
    output logic [REG_AW-1:0]   o_wb_rd,
    output logic                o_wb_reg_write
);

    logic [XLEN-1:0]    m_alu_result;
    logic               m_reg_write;
    logic [1:0]         m_res_src;
    logic [REG_AW-1:0]  m_rd;
    logic [XLEN-1:2]    m_pc_p4;
    logic [2:0]         m_funct3;
    logic               m_mem_write;
    logic               m_mem_read;
    logic [BE_W-1:0]    m_mem_sel;
    logic [XLEN-1:0]    m_wdata;

    logic               ram_en;
    logic               ram_we;
    logic [BE_W-1:0]    ram_be;
    logic [DMEM_AW-1:0] ram_addr;
    logic [XLEN-1:0]    ram_wdata;
    logic [XLEN-1:0]    ram_rdata;

    rv_memory u_rv_memory
    (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_alu_result (i_alu_result),
        .i_reg_write  (i_reg_write),
        .i_mem_read   (i_mem_read),
        .i_mem_write  (i_mem_write),
        .i_rd         (i_rd),
        .i_res_src    (i_res_src),
        .i_funct3     (i_funct3),
        .i_pc_p4      (i_pc_p4),
        .i_rs2_val    (i_rs2_val),
        .i_pc_target  (i_pc_target),
        .o_alu_result (m_alu_result),
        .o_reg_write  (m_reg_write),
        .o_res_src    (m_res_src),
        .o_rd         (m_rd),
        .o_pc_p4      (m_pc_p4),
        .o_funct3     (m_funct3),
        .o_pc_target  (o_pc_target),
        .o_mem_write  (m_mem_write),
        .o_mem_read   (m_mem_read),
        .o_mem_sel    (m_mem_sel),
        .o_wdata      (m_wdata)
    );

    rv_dmem_arbiter u_rv_dmem_arbiter
    (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_core_req   (m_mem_read | m_mem_write),
        .i_core_we    (m_mem_write),
        .i_core_be    (m_mem_sel),
        .i_core_addr  (m_alu_result[DMEM_AW+1:2]),
        .i_core_wdata (m_wdata),
        .i_dbg_req    (i_dbg_req),
        .i_dbg_we     (i_dbg_we),
        .i_dbg_be     (i_dbg_be),
        .i_dbg_addr   (i_dbg_addr),
        .i_dbg_wdata  (i_dbg_wdata),
        .o_dbg_gnt    (o_dbg_gnt),
        .o_dbg_rvalid (o_dbg_rvalid),
        .o_dbg_rdata  (o_dbg_rdata),
        .o_mem_en     (ram_en),
        .o_mem_we     (ram_we),
        .o_mem_be     (ram_be),
        .o_mem_addr   (ram_addr),
        .o_mem_wdata  (ram_wdata),
        .i_mem_rdata  (ram_rdata)
    );

    rv_dmem u_rv_dmem
    (
        .i_clk   (i_clk),
        .i_en    (ram_en),
        .i_we    (ram_we),
        .i_be    (ram_be),
        .i_addr  (ram_addr),
        .i_wdata (ram_wdata),
        .o_rdata (ram_rdata)
    );

    rv_writeback u_rv_writeback
    (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_reg_write    (m_reg_write),
        .i_res_src      (m_res_src),
        .i_rd           (m_rd),
        .i_funct3       (m_funct3),
        .i_alu_result   (m_alu_result),
        .i_pc_p4        (m_pc_p4),
        .i_mem_rdata    (ram_rdata),
        .o_wb_data      (o_wb_data),
        .o_wb_rd        (o_wb_rd),
        .o_wb_reg_write (o_wb_reg_write)
    );

endmodule

`default_nettype wire

/* tb_rv_mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_mem_stage
    import rv_isa_pkg::*;
    import rv_mem_pkg::*;
();

    localparam int          CLK_HALF       = 2;
    localparam int          RESET_CYCLES   = 10;
    localparam int          TIMEOUT_CYCLES = 2000;
    localparam int          GNT_WAIT_MAX   = 16;
    localparam logic [31:0] RNG_SEED       = 32'h2d0bd1d1;

    logic                clk = 1'b0;
    logic                rst_n;
    logic [XLEN-1:0]     alu_result;
    logic                reg_write;
    logic                mem_read;
    logic                mem_write;
    logic [REG_AW-1:0]   rd;
    logic [1:0]          res_src;
    logic [2:0]          funct3;
    logic [XLEN-1:2]     pc_p4;
    logic [XLEN-1:0]     rs2_val;
    logic [XLEN-1:2]     pc_target;
    logic                dbg_req;
    logic                dbg_we;
    logic [BE_W-1:0]     dbg_be;
    logic [DMEM_AW-1:0]  dbg_addr;
    logic [XLEN-1:0]     dbg_wdata;
    logic                dbg_gnt;
    logic                dbg_rvalid;
    logic [XLEN-1:0]     dbg_rdata;
    logic [XLEN-1:2]     pc_target_out;
    logic [XLEN-1:0]     wb_data;
    logic [REG_AW-1:0]   wb_rd;
    logic                wb_reg_write;

    // Byte-wide copy of the data RAM
    logic [7:0] ref_mem [DMEM_WORDS*BE_W];

    rv_mem_stage_top rv_mem_stage_top_i
    (
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .i_alu_result   (alu_result),
        .i_reg_write    (reg_write),
        .i_mem_read     (mem_read),
        .i_mem_write    (mem_write),
        .i_rd           (rd),
        .i_res_src      (res_src),
        .i_funct3       (funct3),
        .i_pc_p4        (pc_p4),
        .i_rs2_val      (rs2_val),
        .i_pc_target    (pc_target),
        .i_dbg_req      (dbg_req),
        .i_dbg_we       (dbg_we),
        .i_dbg_be       (dbg_be),
        .i_dbg_addr     (dbg_addr),
        .i_dbg_wdata    (dbg_wdata),
        .o_dbg_gnt      (dbg_gnt),
        .o_dbg_rvalid   (dbg_rvalid),
        .o_dbg_rdata    (dbg_rdata),
        .o_pc_target    (pc_target_out),
        .o_wb_data      (wb_data),
        .o_wb_rd        (wb_rd),
        .o_wb_reg_write (wb_reg_write)
    );

    always #CLK_HALF clk = ~clk;

    task automatic stop_with_failure();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_word(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                              input string what);
        if (got !== exp)
        begin
            $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            $display("[FAIL] %0t: %s got %b expected %b", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_wb(input logic [XLEN-1:0] got_data, input logic [REG_AW-1:0] got_rd,
                            input logic got_we, input logic [XLEN-1:0] exp_data,
                            input logic [REG_AW-1:0] exp_rd, input logic exp_we,
                            input string what);
        if (got_data !== exp_data || got_rd !== exp_rd || got_we !== exp_we)
        begin
            $display("[FAIL] %0t: %s got data=%h rd=%0d we=%b expected data=%h rd=%0d we=%b",
                     $time, what, got_data, got_rd, got_we, exp_data, exp_rd, exp_we);
            stop_with_failure();
        end
    endtask

    function automatic void ref_write(input int word, input logic [BE_W-1:0] be,
                                      input logic [XLEN-1:0] data);
        for (int i = 0; i < BE_W; i++)
        begin
            if (be[i])
                ref_mem[word*BE_W + i] = data[8*i +: 8];
        end
    endfunction

    // Stores take the low bytes of rs2 starting at the byte address
    function automatic void ref_store(input int word, input int off, input logic [2:0] f3,
                                      input logic [XLEN-1:0] data);
        int nbytes;
        nbytes = (f3 == F3_B) ? 1 : ((f3 == F3_H) ? 2 : 4);
        for (int i = 0; i < nbytes; i++)
            ref_mem[word*BE_W + off + i] = data[8*i +: 8];
    endfunction

    function automatic logic [XLEN-1:0] ref_word(input int word);
        return {ref_mem[word*BE_W + 3], ref_mem[word*BE_W + 2],
                ref_mem[word*BE_W + 1], ref_mem[word*BE_W]};
    endfunction

    function automatic logic [XLEN-1:0] ref_load(input int word, input int off,
                                                 input logic [2:0] f3);
        logic [7:0]  b;
        logic [15:0] h;
        b = ref_mem[word*BE_W + off];
        h = {ref_mem[word*BE_W + (off | 1)], b};
        case (f3)
            F3_B:    return {{(XLEN-8){b[7]}}, b};
            F3_BU:   return {{(XLEN-8){1'b0}}, b};
            F3_H:    return {{(XLEN-16){h[15]}}, h};
            F3_HU:   return {{(XLEN-16){1'b0}}, h};
            default: return ref_word(word);
        endcase
    endfunction

    task automatic set_idle();
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
    endtask

    // The RAM ignores the random upper address bits
    task automatic drive_mem_op(input int word, input int off, input logic [2:0] f3,
                                input logic store, input logic [XLEN-1:0] data,
                                input logic [REG_AW-1:0] dest);
        alu_result                = $urandom();
        alu_result[DMEM_AW+1:0]   = {DMEM_AW'(word), 2'(off)};
        reg_write                 = ~store;
        mem_read                  = ~store;
        mem_write                 = store;
        rd                        = dest;
        res_src                   = RES_MEM;
        funct3                    = f3;
        rs2_val                   = data;
    endtask

    task automatic finish_instr();
        @(posedge clk);
        @(negedge clk);
        set_idle();
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic drive_debug(input logic we, input logic [BE_W-1:0] be, input int word,
                               input logic [XLEN-1:0] data);
        dbg_req   = 1'b1;
        dbg_we    = we;
        dbg_be    = be;
        dbg_addr  = DMEM_AW'(word);
        dbg_wdata = data;
    endtask

    task automatic wait_for_grant();
        int waited;
        waited = 0;
        #1;
        while (!dbg_gnt)
        begin
            if (waited == GNT_WAIT_MAX)
            begin
                $display("Debug request was not granted within %0d cycles", GNT_WAIT_MAX);
                stop_with_failure();
            end
            @(negedge clk);
            #1;
            waited++;
        end
    endtask

    task automatic debug_access(input int word, input logic we, input logic [BE_W-1:0] be,
                                input logic [XLEN-1:0] data, output logic [XLEN-1:0] rdata);
        drive_debug(we, be, word, data);
        wait_for_grant();
        @(posedge clk);
        @(negedge clk);
        dbg_req = 1'b0;
        check_flag(dbg_rvalid, ~we, "debug rvalid one cycle after grant");
        if (we)
            ref_write(word, be, data);
        rdata = dbg_rdata;
    endtask

    task automatic test_reset_state();
        check_flag(wb_reg_write, 1'b0, "wb_reg_write after reset");
        check_flag(dbg_rvalid, 1'b0, "debug rvalid after reset");
        drive_debug(1'b1, '1, 0, $urandom());
        #1;
        check_flag(dbg_gnt, 1'b1, "debug grant with idle core");
        @(posedge clk);
        @(negedge clk);
        dbg_req = 1'b0;
        ref_write(0, '1, dbg_wdata);
    endtask

    task automatic store_readback(input logic [2:0] f3, input int off);
        int              word;
        logic [XLEN-1:0] data;
        logic [XLEN-1:0] got;
        word = $urandom_range(DMEM_WORDS-1, 0);
        debug_access(word, 1'b1, '1, $urandom(), got);
        data = $urandom();
        drive_mem_op(word, off, f3, 1'b1, data, '0);
        finish_instr();
        ref_store(word, off, f3, data);
        debug_access(word, 1'b0, '0, '0, got);
        check_word(got, ref_word(word), "debug readback after store");
    endtask

    task automatic test_store_lanes();
        repeat (3)
        begin
            for (int off = 0; off < 4; off++)
                store_readback(F3_B, off);
            store_readback(F3_H, 0);
            store_readback(F3_H, 2);
            store_readback(F3_W, 0);
        end
    endtask

    // Fill forces every sign bit set or clear
    task automatic load_check(input logic [2:0] f3, input int off, input logic neg);
        int                word;
        logic [XLEN-1:0]   fill;
        logic [XLEN-1:0]   unused;
        logic [REG_AW-1:0] dest;
        word = $urandom_range(DMEM_WORDS-1, 0);
        fill = neg ? ($urandom() | 32'h8080_8080) : ($urandom() & 32'h7f7f_7f7f);
        dest = REG_AW'($urandom());
        debug_access(word, 1'b1, '1, fill, unused);
        drive_mem_op(word, off, f3, 1'b0, '0, dest);
        finish_instr();
        check_wb(wb_data, wb_rd, wb_reg_write, ref_load(word, off, f3), dest, 1'b1, "load");
    endtask

    task automatic test_loads();
        for (int neg = 0; neg < 2; neg++)
        begin
            for (int off = 0; off < 4; off++)
            begin
                load_check(F3_B, off, neg[0]);
                load_check(F3_BU, off, neg[0]);
            end
            for (int off = 0; off < 4; off += 2)
            begin
                load_check(F3_H, off, neg[0]);
                load_check(F3_HU, off, neg[0]);
            end
            load_check(F3_W, 0, neg[0]);
        end
    endtask

    task automatic test_result_select();
        logic [XLEN-1:0]   exp;
        for (int i = 0; i < 8; i++)
        begin
            alu_result = $urandom();
            pc_p4      = (XLEN-2)'($urandom());
            pc_target  = (XLEN-2)'($urandom());
            rd         = REG_AW'($urandom());
            res_src    = i[0] ? RES_PC4 : RES_ALU;
            funct3     = F3_W;
            reg_write  = 1'b1;
            exp        = i[0] ? {pc_p4, 2'b00} : alu_result;
            @(posedge clk);
            @(negedge clk);
            check_word({pc_target_out, 2'b00}, {pc_target, 2'b00}, "pc_target passthrough");
            set_idle();
            @(posedge clk);
            @(negedge clk);
            check_wb(wb_data, wb_rd, wb_reg_write, exp, rd, 1'b1, "result select");
        end
    endtask

    task automatic test_debug_contention();
        int              word_a;
        int              word_b;
        logic [BE_W-1:0] be;
        logic [XLEN-1:0] data;
        logic [XLEN-1:0] unused;
        word_a = $urandom_range(DMEM_WORDS-1, 0);
        word_b = word_a ^ 1;
        debug_access(word_a, 1'b1, '1, $urandom(), unused);
        debug_access(word_b, 1'b1, '1, $urandom(), unused);
        be   = BE_W'($urandom_range(15, 1));
        data = $urandom();
        drive_mem_op(word_a, 0, F3_W, 1'b0, '0, REG_AW'(7));
        @(posedge clk);
        @(negedge clk);
        set_idle();
        // Core owns the RAM in this cycle
        drive_debug(1'b1, be, word_b, data);
        #1;
        check_flag(dbg_gnt, 1'b0, "debug grant during core load");
        @(posedge clk);
        @(negedge clk);
        check_wb(wb_data, wb_rd, wb_reg_write, ref_word(word_a), REG_AW'(7), 1'b1,
                 "load under debug contention");
        #1;
        check_flag(dbg_gnt, 1'b1, "debug grant in first idle cycle");
        @(posedge clk);
        @(negedge clk);
        dbg_req = 1'b0;
        ref_write(word_b, be, data);
        drive_mem_op(word_b, 0, F3_W, 1'b0, '0, REG_AW'(9));
        finish_instr();
        check_wb(wb_data, wb_rd, wb_reg_write, ref_word(word_b), REG_AW'(9), 1'b1,
                 "load after debug write");
    endtask

    task automatic test_store_then_load();
        int              word;
        int              off;
        logic [2:0]      f3;
        logic [XLEN-1:0] data;
        logic [XLEN-1:0] unused;
        for (int i = 0; i < 6; i++)
        begin
            word = $urandom_range(DMEM_WORDS-1, 0);
            case (i % 3)
                0:
                begin
                    f3  = F3_B;
                    off = $urandom_range(3, 0);
                end
                1:
                begin
                    f3  = F3_H;
                    off = 2 * $urandom_range(1, 0);
                end
                default:
                begin
                    f3  = F3_W;
                    off = 0;
                end
            endcase
            debug_access(word, 1'b1, '1, $urandom(), unused);
            data = $urandom();
            drive_mem_op(word, off, f3, 1'b1, data, '0);
            @(posedge clk);
            @(negedge clk);
            ref_store(word, off, f3, data);
            // Back to back with the store
            drive_mem_op(word, 0, F3_W, 1'b0, '0, REG_AW'(i + 1));
            finish_instr();
            check_wb(wb_data, wb_rd, wb_reg_write, ref_word(word), REG_AW'(i + 1), 1'b1,
                     "load right after store");
        end
    endtask

    initial
    begin
        void'($urandom(RNG_SEED));
        rst_n      = 1'b0;
        alu_result = '0;
        rd         = '0;
        res_src    = RES_ALU;
        funct3     = F3_W;
        pc_p4      = '0;
        rs2_val    = '0;
        pc_target  = '0;
        dbg_we     = 1'b0;
        dbg_be     = '0;
        dbg_addr   = '0;
        dbg_wdata  = '0;
        // Strobes stay active all through reset
        dbg_req    = 1'b1;
        reg_write  = 1'b1;
        mem_read   = 1'b1;
        mem_write  = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n   = 1'b1;
        set_idle();
        dbg_req = 1'b0;
        test_reset_state();
        test_store_lanes();
        test_loads();
        test_result_select();
        test_debug_contention();
        test_store_then_load();
        $display("all tests passed");
        $finish;
    end

    // Ends a run that hangs
    initial
    begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Simulation timed out after %0d cycles", TIMEOUT_CYCLES);
        stop_with_failure();
    end

endmodule

`default_nettype wire

/* sim.f */
rv_isa_pkg.sv
rv_mem_pkg.sv
core_memory.sv
rv_memory.sv
rv_dmem_arbiter.sv
rv_dmem.sv
rv_writeback.sv
rv_mem_stage_top.sv
tb_rv_mem_stage.sv

/* Bender.yml */
package:
  name: rv_mem_stage

sources:
  - rv_isa_pkg.sv
  - rv_mem_pkg.sv
  - core_memory.sv
  - rv_memory.sv
  - rv_dmem_arbiter.sv
  - rv_dmem.sv
  - rv_writeback.sv
  - rv_mem_stage_top.sv
  - target: test
    files:
      - tb_rv_mem_stage.sv
